// File: rtl/sb_consts.svh
`ifndef SB_CONSTS_SVH
`define SB_CONSTS_SVH

// Number of store buffer entries, 4, 8 or 16
`define SB_DEPTH 8

// ROB instruction tag width
`define SB_TAG_W 8

// Address and data width
`define SB_XLEN 32

`endif

// File: rtl/mem_op_pkg.sv
`default_nettype none

package mem_op_pkg;

`include "sb_consts.svh"

    typedef logic [`SB_XLEN-1:0] addr_t;   // Byte address
    typedef logic [`SB_XLEN-1:0] data_t;   // Store or load data word
    typedef logic [1:0]          mem_size_t;

    // funct3 encodings of the load and store ops
    typedef enum logic [2:0] {
        op_b  = 3'd0,
        op_h  = 3'd1,
        op_w  = 3'd2,
        op_bu = 3'd4,
        op_hu = 3'd5
    } mem_op_e;

    function automatic mem_size_t mem_size(mem_op_e op);
        return op[1:0];   // Drop the unsigned bit
    endfunction

endpackage

`default_nettype wire

// File: rtl/sb_pkg.sv
`default_nettype none

package sb_pkg;

`include "sb_consts.svh"

    // Tag handed out by the ROB with each store
    typedef logic [`SB_TAG_W-1:0] sb_tag_t;

    // Entry index
    typedef logic [$clog2(`SB_DEPTH)-1:0] sb_idx_t;

    // One bit per entry
    typedef logic [`SB_DEPTH-1:0] sb_mask_t;

endpackage

`default_nettype wire

// File: rtl/sb_entry_if.sv
`timescale 1ns/1ps
`default_nettype none

interface sb_entry_if
    import mem_op_pkg::*;
();

    logic    wr_en;    // Allocate this entry for the store on the bus
    logic    st_acc;   // Some entry accepts the store this cycle
    logic    valid;
    logic    ld_hit;   // Load matches address and size
    logic    cm_hit;   // Commit tag matches
    addr_t   addr;
    data_t   data;
    mem_op_e op;

    modport alloc (
        output wr_en,
        output st_acc,
        input  valid
    );

    modport entry (
        input  wr_en,
        input  st_acc,
        output valid,
        output ld_hit,
        output cm_hit,
        output data,
        output addr,
        output op
    );

    modport readout (
        input ld_hit,
        input cm_hit,
        input data,
        input addr,
        input op
    );

endinterface

`default_nettype wire

// File: rtl/sb_alloc.sv
`timescale 1ns/1ps
`default_nettype none

`include "sb_consts.svh"

module sb_alloc
    import sb_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire logic     st_valid,
    output logic          full,
    sb_entry_if.alloc     ents [`SB_DEPTH]
);

    sb_mask_t valid_vec;
    sb_mask_t wr_vec;
    sb_idx_t  free_idx;
    logic     accept;

    // Flatten the entry bundles
    for (genvar i = 0; i < `SB_DEPTH; i++) begin : g_port
        assign valid_vec[i]   = ents[i].valid;
        assign ents[i].wr_en  = wr_vec[i];
        assign ents[i].st_acc = accept;
    end

    // Lowest free entry wins
    always_comb begin
        free_idx = '0;
        for (int i = `SB_DEPTH - 1; i >= 0; i--) begin
            if (!valid_vec[i]) begin
                free_idx = sb_idx_t'(i);
            end
        end
    end

    assign full   = &valid_vec;
    assign accept = st_valid && !full;
    assign wr_vec = accept ? (sb_mask_t'(1) << free_idx) : '0;

    // A held store must never be overwritten by a new one
    a_no_overwrite: assert property (
        @(posedge clk) disable iff (!rst_n)
        (wr_vec & valid_vec) == '0
    );

    // The core holds st_valid back while the buffer reports full
    a_no_store_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        st_valid |-> !full
    );

endmodule

`default_nettype wire

// File: rtl/sb_entry.sv
`timescale 1ns/1ps
`default_nettype none

`include "sb_consts.svh"

module sb_entry
    import mem_op_pkg::*;
    import sb_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  wire logic    flush,
    input  wire addr_t   st_addr,
    input  wire data_t   st_data,
    input  wire mem_op_e st_op,
    input  wire sb_tag_t st_tag,
    input  wire addr_t   ld_addr,
    input  wire mem_op_e ld_op,
    input  wire logic    commit_valid,
    input  wire sb_tag_t commit_tag,
    sb_entry_if.entry    port
);

    logic    valid_q;
    addr_t   addr_q;
    data_t   data_q;
    mem_op_e op_q;
    sb_tag_t tag_q;

    data_t   st_trunc;
    logic    st_match;
    logic    coalesce;
    logic    ld_match;
    logic    cm_match;

    // Keep only the bytes the store actually writes
    always_comb begin
        case (mem_size(st_op))
            2'd0:    st_trunc = data_t'(st_data[7:0]);
            2'd1:    st_trunc = data_t'(st_data[15:0]);
            default: st_trunc = st_data;
        endcase
    end

    assign st_match = valid_q && (addr_q == st_addr) && (mem_size(op_q) == mem_size(st_op));
    assign coalesce = port.st_acc && st_match;   // Newer store replaces this one
    assign ld_match = valid_q && (addr_q == ld_addr) && (mem_size(op_q) == mem_size(ld_op));
    assign cm_match = valid_q && commit_valid && (tag_q == commit_tag);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (flush || cm_match || coalesce) begin
            valid_q <= 1'b0;
        end else if (port.wr_en) begin
            valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (port.wr_en) begin
            addr_q <= st_addr;
            data_q <= st_trunc;
            op_q   <= st_op;
            tag_q  <= st_tag;
        end
    end

    assign port.valid  = valid_q;
    assign port.ld_hit = ld_match;
    assign port.cm_hit = cm_match;
    assign port.addr   = addr_q;
    assign port.data   = data_q;
    assign port.op     = op_q;

endmodule

`default_nettype wire

// File: rtl/sb_readout.sv
`timescale 1ns/1ps
`default_nettype none

`include "sb_consts.svh"

module sb_readout
    import mem_op_pkg::*;
    import sb_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  wire logic    flush,
    input  wire logic    ld_valid,
    input  wire mem_op_e ld_op,
    sb_entry_if.readout  ents [`SB_DEPTH],
    output logic         ld_done,
    output logic         ld_hit,
    output data_t        ld_data,
    output logic         mem_wr_en,
    output addr_t        mem_wr_addr,
    output data_t        mem_wr_data,
    output mem_op_e      mem_wr_op
);

    sb_mask_t ld_hit_vec;
    sb_mask_t cm_hit_vec;
    addr_t    ent_addr [`SB_DEPTH];
    data_t    ent_data [`SB_DEPTH];
    mem_op_e  ent_op   [`SB_DEPTH];

    data_t    ld_raw;
    data_t    ld_ext;
    addr_t    cm_addr;
    data_t    cm_data;
    mem_op_e  cm_op;

    for (genvar i = 0; i < `SB_DEPTH; i++) begin : g_port
        assign ld_hit_vec[i] = ents[i].ld_hit;
        assign cm_hit_vec[i] = ents[i].cm_hit;
        assign ent_addr[i]   = ents[i].addr;
        assign ent_data[i]   = ents[i].data;
        assign ent_op[i]     = ents[i].op;
    end

    // Hits are one-hot, so a plain scan is enough
    always_comb begin
        ld_raw  = '0;
        cm_addr = '0;
        cm_data = '0;
        cm_op   = op_w;
        for (int i = 0; i < `SB_DEPTH; i++) begin
            if (ld_hit_vec[i]) begin
                ld_raw = ent_data[i];
            end
            if (cm_hit_vec[i]) begin
                cm_addr = ent_addr[i];
                cm_data = ent_data[i];
                cm_op   = ent_op[i];
            end
        end
    end

    always_comb begin
        case (ld_op)
            op_b:    ld_ext = {{(`SB_XLEN - 8){ld_raw[7]}}, ld_raw[7:0]};
            op_h:    ld_ext = {{(`SB_XLEN - 16){ld_raw[15]}}, ld_raw[15:0]};
            op_bu:   ld_ext = data_t'(ld_raw[7:0]);
            op_hu:   ld_ext = data_t'(ld_raw[15:0]);
            default: ld_ext = ld_raw;   // LW
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ld_done   <= 1'b0;
            ld_hit    <= 1'b0;
            mem_wr_en <= 1'b0;
        end else begin
            ld_done   <= ld_valid && !flush;
            ld_hit    <= ld_valid && !flush && (|ld_hit_vec);
            mem_wr_en <= (|cm_hit_vec) && !flush;
        end
    end

    always_ff @(posedge clk) begin
        if (ld_valid) begin
            ld_data <= ld_ext;   // Zero on a miss
        end
        if (|cm_hit_vec) begin
            mem_wr_addr <= cm_addr;
            mem_wr_data <= cm_data;
            mem_wr_op   <= cm_op;
        end
    end

    // Coalescing keeps address and size unique, the ROB keeps tags unique
    a_ld_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(ld_hit_vec));
    a_cm_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(cm_hit_vec));

endmodule

`default_nettype wire

// File: rtl/store_buffer_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "sb_consts.svh"

module store_buffer_top
    import mem_op_pkg::*;
    import sb_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  wire logic    flush,          // Exception or mret
    input  wire logic    st_valid,
    input  wire addr_t   st_addr,
    input  wire data_t   st_data,
    input  wire mem_op_e st_op,
    input  wire sb_tag_t st_tag,
    output logic         full,
    input  wire logic    ld_valid,
    input  wire addr_t   ld_addr,
    input  wire mem_op_e ld_op,
    output logic         ld_done,
    output logic         ld_hit,
    output data_t        ld_data,
    input  wire logic    commit_valid,
    input  wire sb_tag_t commit_tag,
    output logic         mem_wr_en,
    output addr_t        mem_wr_addr,
    output data_t        mem_wr_data,
    output mem_op_e      mem_wr_op
);

    sb_entry_if u_ents [`SB_DEPTH] ();

    sb_alloc u_alloc (
        .clk      (clk),
        .rst_n    (rst_n),
        .st_valid (st_valid),
        .full     (full),
        .ents     (u_ents)
    );

    for (genvar i = 0; i < `SB_DEPTH; i++) begin : g_entry
        sb_entry u_entry (
            .clk          (clk),
            .rst_n        (rst_n),
            .flush        (flush),
            .st_addr      (st_addr),
            .st_data      (st_data),
            .st_op        (st_op),
            .st_tag       (st_tag),
            .ld_addr      (ld_addr),
            .ld_op        (ld_op),
            .commit_valid (commit_valid),
            .commit_tag   (commit_tag),
            .port         (u_ents[i])
        );
    end

    sb_readout u_readout (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .ld_valid    (ld_valid),
        .ld_op       (ld_op),
        .ents        (u_ents),
        .ld_done     (ld_done),
        .ld_hit      (ld_hit),
        .ld_data     (ld_data),
        .mem_wr_en   (mem_wr_en),
        .mem_wr_addr (mem_wr_addr),
        .mem_wr_data (mem_wr_data),
        .mem_wr_op   (mem_wr_op)
    );

endmodule

`default_nettype wire

// File: sim/sb_tb_model.svh
`ifndef SB_TB_MODEL_SVH
`define SB_TB_MODEL_SVH

// One held store, data already cut to its size
typedef struct packed {
    addr_t   addr;
    data_t   data;
    mem_op_e op;
    sb_tag_t tag;
} model_ent_t;

model_ent_t model_q[$];

logic    exp_ld_done;
logic    exp_ld_hit;
data_t   exp_ld_data;
logic    exp_wr_en;
addr_t   exp_wr_addr;
data_t   exp_wr_data;
mem_op_e exp_wr_op;

function automatic data_t size_mask(mem_op_e op);
    case (op[1:0])
        2'd0:    return 32'h0000_00ff;
        2'd1:    return 32'h0000_ffff;
        default: return 32'hffff_ffff;
    endcase
endfunction

function automatic data_t extend_load(data_t d, mem_op_e op);
    data_t v;
    v = d & size_mask(op);
    if (op == op_b && v[7]) begin
        v = v | 32'hffff_ff00;
    end
    if (op == op_h && v[15]) begin
        v = v | 32'hffff_0000;
    end
    return v;
endfunction

function automatic int find_match(addr_t a, mem_op_e op);
    foreach (model_q[i]) begin
        if (model_q[i].addr == a && model_q[i].op[1:0] == op[1:0]) begin
            return i;
        end
    end
    return -1;
endfunction

function automatic int find_tag(sb_tag_t t);
    foreach (model_q[i]) begin
        if (model_q[i].tag == t) begin
            return i;
        end
    end
    return -1;
endfunction

task automatic model_reset();
    model_q.delete();
    exp_ld_done = 1'b0;
    exp_ld_hit  = 1'b0;
    exp_wr_en   = 1'b0;
endtask

// Predicts the registered outputs after the next edge, then updates the contents
task automatic model_step(input logic st_v, input addr_t st_a, input data_t st_d,
                          input mem_op_e st_o, input sb_tag_t st_t, input logic ld_v,
                          input addr_t ld_a, input mem_op_e ld_o, input logic cm_v,
                          input sb_tag_t cm_t, input logic fl);
    int         li;
    int         ci;
    int         si;
    model_ent_t e;
    li = find_match(ld_a, ld_o);
    ci = cm_v ? find_tag(cm_t) : -1;
    exp_ld_done = ld_v && !fl;
    exp_ld_hit  = ld_v && !fl && (li >= 0);
    if (ld_v) begin
        exp_ld_data = (li >= 0) ? extend_load(model_q[li].data, ld_o) : '0;
    end
    exp_wr_en = (ci >= 0) && !fl;
    if (ci >= 0) begin
        exp_wr_addr = model_q[ci].addr;
        exp_wr_data = model_q[ci].data;
        exp_wr_op   = model_q[ci].op;
    end
    if (fl) begin
        model_q.delete();   // Store on the same edge is lost too
    end else begin
        if (ci >= 0) begin
            model_q.delete(ci);
        end
        if (st_v) begin
            si = find_match(st_a, st_o);
            if (si >= 0) begin
                model_q.delete(si);   // Coalesced away
            end
            e.addr = st_a;
            e.data = st_d & size_mask(st_o);
            e.op   = st_o;
            e.tag  = st_t;
            model_q.push_back(e);
        end
    end
endtask

`endif

// File: sim/tb_store_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "sb_consts.svh"

module tb_store_buffer
    import mem_op_pkg::*;
    import sb_pkg::*;
();

    localparam int RAND_CYCLES = 600;
    localparam int TEST_CYCLES = RAND_CYCLES + 100;   // Directed part is well under 100

    logic    clk;
    logic    rst_n;
    logic    flush;
    logic    st_valid;
    addr_t   st_addr;
    data_t   st_data;
    mem_op_e st_op;
    sb_tag_t st_tag;
    logic    full;
    logic    ld_valid;
    addr_t   ld_addr;
    mem_op_e ld_op;
    logic    ld_done;
    logic    ld_hit;
    data_t   ld_data;
    logic    commit_valid;
    sb_tag_t commit_tag;
    logic    mem_wr_en;
    addr_t   mem_wr_addr;
    data_t   mem_wr_data;
    mem_op_e mem_wr_op;

    int      errors;
    int      checks;
    sb_tag_t tag_ctr;
    sb_tag_t last_tag;
    sb_tag_t tag_hist[$];
    sb_tag_t t0;
    mem_op_e load_ops[5] = '{op_b, op_h, op_w, op_bu, op_hu};

`include "sb_tb_model.svh"

    store_buffer_top u_store_buffer_top (.*);

    always #10 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_outputs();
        check_value("full", full, model_q.size() == `SB_DEPTH);
        check_value("ld_done", ld_done, exp_ld_done);
        check_value("ld_hit", ld_hit, exp_ld_hit);
        if (exp_ld_done) begin
            check_value("ld_data", ld_data, exp_ld_data);
        end
        check_value("mem_wr_en", mem_wr_en, exp_wr_en);
        if (exp_wr_en) begin
            check_value("mem_wr_addr", mem_wr_addr, exp_wr_addr);
            check_value("mem_wr_data", mem_wr_data, exp_wr_data);
            check_value("mem_wr_op", mem_wr_op, exp_wr_op);
        end
    endtask

    task automatic set_idle();
        flush        = 1'b0;
        st_valid     = 1'b0;
        st_addr      = '0;
        st_data      = '0;
        st_op        = op_w;
        st_tag       = '0;
        ld_valid     = 1'b0;
        ld_addr      = '0;
        ld_op        = op_w;
        commit_valid = 1'b0;
        commit_tag   = '0;
    endtask

    task automatic set_store(input addr_t a, input data_t d, input mem_op_e op);
        while (find_tag(tag_ctr) >= 0) begin
            tag_ctr++;   // ROB never reuses a live tag
        end
        st_valid = 1'b1;
        st_addr  = a;
        st_data  = d;
        st_op    = op;
        st_tag   = tag_ctr;
        last_tag = tag_ctr;
        tag_hist.push_back(tag_ctr);
        tag_ctr++;
    endtask

    task automatic set_load(input addr_t a, input mem_op_e op);
        ld_valid = 1'b1;
        ld_addr  = a;
        ld_op    = op;
    endtask

    task automatic set_commit(input sb_tag_t t);
        commit_valid = 1'b1;
        commit_tag   = t;
    endtask

    // Inputs are set at a falling edge, results checked at the next one
    task automatic step();
        model_step(st_valid, st_addr, st_data, st_op, st_tag, ld_valid, ld_addr, ld_op,
                   commit_valid, commit_tag, flush);
        @(negedge clk);
        check_outputs();
        set_idle();
    endtask

    task automatic load_expect(input addr_t a, input mem_op_e op, input logic hit,
                               input data_t d);
        set_load(a, op);
        step();
        check_value("ld_hit", ld_hit, hit);
        if (hit) begin
            check_value("ld_data", ld_data, d);
        end
    endtask

    function automatic addr_t rand_addr();
        return 32'h1000 + 32'($urandom_range(0, 5)) * 4;   // Small pool, many matches
    endfunction

    initial begin
        #(TEST_CYCLES * 20 + 2000);
        $display("timeout: the test did not reach its end in time");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        void'($urandom(32'h9e62));
        errors  = 0;
        checks  = 0;
        tag_ctr = '0;
        clk     = 1'b0;
        rst_n   = 1'b0;
        set_idle();
        model_reset();
        repeat (5) @(posedge clk);
        @(negedge clk);
        check_outputs();
        rst_n = 1'b1;

        // Forwarding and extension
        set_store(32'h1000, 32'h8000_ff80, op_w);
        step();
        set_store(32'h1004, 32'h1234_8001, op_h);
        step();
        set_store(32'h1008, 32'h0000_12ab, op_b);
        step();
        load_expect(32'h1000, op_w, 1'b1, 32'h8000_ff80);
        load_expect(32'h1004, op_h, 1'b1, 32'hffff_8001);
        load_expect(32'h1004, op_hu, 1'b1, 32'h0000_8001);
        load_expect(32'h1008, op_b, 1'b1, 32'hffff_ffab);
        load_expect(32'h1008, op_bu, 1'b1, 32'h0000_00ab);
        load_expect(32'h1000, op_b, 1'b0, 32'h0);

        // Coalescing, then commit of the replaced store
        set_store(32'h1010, 32'h1111_1111, op_w);
        t0 = last_tag;
        step();
        set_store(32'h1010, 32'h2222_2222, op_w);
        step();
        set_commit(t0);
        step();
        check_value("mem_wr_en", mem_wr_en, 1'b0);
        load_expect(32'h1010, op_w, 1'b1, 32'h2222_2222);

        // Commit writes once and frees the entry
        set_commit(last_tag);
        step();
        check_value("mem_wr_en", mem_wr_en, 1'b1);
        check_value("mem_wr_addr", mem_wr_addr, 32'h1010);
        check_value("mem_wr_data", mem_wr_data, 32'h2222_2222);
        load_expect(32'h1010, op_w, 1'b0, 32'h0);

        // Fill up, then drain one
        for (int n = 0; model_q.size() < `SB_DEPTH; n++) begin
            set_store(32'h2000 + 32'(n) * 4, 32'(n) + 32'h50, op_w);
            step();
        end
        check_value("full", full, 1'b1);
        set_commit(last_tag);
        step();
        check_value("full", full, 1'b0);

        // Flush empties everything
        flush = 1'b1;
        step();
        load_expect(32'h1000, op_w, 1'b0, 32'h0);
        set_commit(tag_hist[0]);
        step();
        check_value("mem_wr_en", mem_wr_en, 1'b0);

        // Same-edge cases
        set_store(32'h3000, 32'hdead_beef, op_w);
        set_load(32'h3000, op_w);
        t0 = last_tag;
        step();
        check_value("ld_hit", ld_hit, 1'b0);
        set_store(32'h3004, 32'h0bad_f00d, op_w);
        set_load(32'h3000, op_w);
        set_commit(t0);
        step();
        check_value("ld_hit", ld_hit, 1'b1);
        check_value("mem_wr_en", mem_wr_en, 1'b1);

        // Random traffic
        for (int c = 0; c < RAND_CYCLES; c++) begin
            if (model_q.size() < `SB_DEPTH && $urandom_range(0, 99) < 55) begin
                set_store(rand_addr(), $urandom(), mem_op_e'($urandom_range(0, 2)));
            end
            if ($urandom_range(0, 99) < 50) begin
                set_load(rand_addr(), load_ops[$urandom_range(0, 4)]);
            end
            if (tag_hist.size() > 0 && $urandom_range(0, 99) < 35) begin
                set_commit(tag_hist[tag_hist.size() - 1 -
                                    $urandom_range(0, (tag_hist.size() > 16) ? 15 :
                                                      tag_hist.size() - 1)]);
            end
            flush = ($urandom_range(0, 99) < 2);
            step();
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+rtl
+incdir+sim
rtl/mem_op_pkg.sv
rtl/sb_pkg.sv
rtl/sb_entry_if.sv
rtl/sb_alloc.sv
rtl/sb_entry.sv
rtl/sb_readout.sv
rtl/store_buffer_top.sv
sim/tb_store_buffer.sv
